// File: hdl/i2s_cfg_pkg.sv
package i2s_cfg_pkg;

    ////////////////////////////////////////////////
    // Receiver sizing
    ////////////////////////////////////////////////

    // Width of one received audio sample
    localparam int SAMPLE_W = 16;

    // Slot bit position counter, must reach SAMPLE_W
    localparam int CNT_W = 5;

    ////////////////////////////////////////////////
    // Pin synchronizer
    ////////////////////////////////////////////////

    localparam int SYNC_STAGES = 2;    // Metastability flops per pin

endpackage

// File: hdl/i2s_types_pkg.sv
package i2s_types_pkg;

    ////////////////////////////////////////////////
    // Data vectors
    ////////////////////////////////////////////////

    // One audio word, MSB first on the wire
    typedef logic [i2s_cfg_pkg::SAMPLE_W-1:0] sample_t;

    // Bit position inside the current slot
    typedef logic [i2s_cfg_pkg::CNT_W-1:0] bit_cnt_t;

    ////////////////////////////////////////////////
    // Frame control states
    ////////////////////////////////////////////////

    // ST_ALIGN   waiting for first left slot
    // ST_LEFT    inside a left slot (ws low)
    // ST_RIGHT   inside a right slot (ws high)
    typedef enum logic [1:0] {
        ST_ALIGN = 2'd0,
        ST_LEFT  = 2'd1,
        ST_RIGHT = 2'd2
    } rx_state_t;

endpackage

// File: hdl/i2s_bus_if.sv
// Serial bus after synchronization to clk
// All fields are registered together in i2s_sync and
// only meaningful in cycles where sck_rise is high
interface i2s_bus_if;

    logic sck_rise;    // One clk pulse per sck rising edge
    logic sd_bit;      // Data bit taken at that edge
    logic ws_lvl;      // Word select level taken at that edge
    logic ws_flip;     // ws differs from previous sck rise

    // Driver side, the synchronizer
    modport src (
        output sck_rise,
        output sd_bit,
        output ws_lvl,
        output ws_flip
    );

    // Counter, frame control and shifter
    modport snk (
        input sck_rise,
        input sd_bit,
        input ws_lvl,
        input ws_flip
    );

endinterface

// File: hdl/i2s_sync.sv
module i2s_sync (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   sck_pin,
    input  logic   sd_pin,
    input  logic   ws_pin,
    i2s_bus_if.src bus
);
    import i2s_cfg_pkg::*;

    logic [SYNC_STAGES-1:0] sck_meta;    // Metastability chain, sck
    logic [SYNC_STAGES-1:0] sd_meta;     // Metastability chain, sd
    logic [SYNC_STAGES-1:0] ws_meta;     // Metastability chain, ws
    logic                   sck_dly;     // Previous synced sck level
    logic                   sck_edge;    // Low to high seen on synced sck

    ////////////////////////////////////////////////
    // Pin synchronizers
    ////////////////////////////////////////////////

    // All three pins see the same depth so sd and ws stay
    // lined up with the sck edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_meta <= '0;
            sd_meta  <= '0;
            ws_meta  <= '0;
            sck_dly  <= 1'b0;
        end
        else
        begin
            sck_meta <= {sck_meta[SYNC_STAGES-2:0], sck_pin};
            sd_meta  <= {sd_meta[SYNC_STAGES-2:0], sd_pin};
            ws_meta  <= {ws_meta[SYNC_STAGES-2:0], ws_pin};
            sck_dly  <= sck_meta[SYNC_STAGES-1];    // Edge reference
        end
    end

    assign sck_edge = sck_meta[SYNC_STAGES-1] && !sck_dly;

    ////////////////////////////////////////////////
    // Bus register, one stage after edge detect
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bus.sck_rise <= 1'b0;
            bus.sd_bit   <= 1'b0;
            bus.ws_lvl   <= 1'b0;    // Idle level counts as left
            bus.ws_flip  <= 1'b0;
        end
        else
        begin
            bus.sck_rise <= sck_edge;
            bus.ws_flip  <= sck_edge && (ws_meta[SYNC_STAGES-1] != bus.ws_lvl);
            if (sck_edge)
            begin
                bus.sd_bit <= sd_meta[SYNC_STAGES-1];    // Sample data on the edge
                bus.ws_lvl <= ws_meta[SYNC_STAGES-1];    // Also the previous ws level
            end
        end
    end

endmodule

// File: hdl/i2s_bit_counter.sv
module i2s_bit_counter (
    input  logic   clk,
    input  logic   rst_n,
    i2s_bus_if.snk bus,
    output logic   take_bit
);
    import i2s_cfg_pkg::*;
    import i2s_types_pkg::*;

    bit_cnt_t bit_cnt;    // Bits seen so far in this slot
    logic     cnt_full;   // Slot already gave SAMPLE_W bits

    assign cnt_full = (bit_cnt == bit_cnt_t'(SAMPLE_W));

    // Shifter may only take bits while the word still has room
    // Long slots stop here, extra LSBs fall away
    assign take_bit = (bit_cnt < bit_cnt_t'(SAMPLE_W));

    ////////////////////////////////////////////////
    // Slot position counter
    ////////////////////////////////////////////////

    // The bit at the flip rise is still the old slot's LSB,
    // it is counted by take_bit above before the clear lands
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt <= '0;
        end
        else if (bus.sck_rise)
        begin
            if (bus.ws_flip)
                bit_cnt <= '0;                  // Next rise is the new MSB
            else if (!cnt_full)
                bit_cnt <= bit_cnt + 1'b1;
            // saturate, stays at SAMPLE_W until the flip
        end
    end

endmodule

// File: hdl/i2s_frame_ctrl.sv
module i2s_frame_ctrl (
    input  logic   clk,
    input  logic   rst_n,
    i2s_bus_if.snk bus,
    output logic   word_done,
    output logic   word_right,
    output logic   sample_valid
);
    import i2s_types_pkg::*;

    rx_state_t state;        // Current slot tracking
    rx_state_t state_nxt;
    logic      slot_end;     // ws flip on an sck rise

    assign slot_end = bus.sck_rise && bus.ws_flip;

    ////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////

    always_comb
    begin
        state_nxt = state;
        if (slot_end)
        begin
            case (state)
                ST_ALIGN:
                begin
                    // Only a fall of ws starts a frame
                    if (!bus.ws_lvl)
                        state_nxt = ST_LEFT;
                end
                ST_LEFT:  state_nxt = ST_RIGHT;
                ST_RIGHT: state_nxt = ST_LEFT;
                default:  state_nxt = ST_ALIGN;    // Unused code, realign
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_ALIGN;
        else
            state <= state_nxt;
    end

    ////////////////////////////////////////////////
    // Word latch control
    ////////////////////////////////////////////////

    // Slot ending now belongs to the state we are leaving
    // Nothing is latched while still aligning
    assign word_done  = slot_end && ((state == ST_LEFT) || (state == ST_RIGHT));
    assign word_right = (state == ST_RIGHT);

    // Pair strobe, one cycle after the right word is latched
    // so both holding registers are already updated
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sample_valid <= 1'b0;
        else
            sample_valid <= word_done && word_right;
    end

endmodule

// File: hdl/i2s_word_shifter.sv
module i2s_word_shifter (
    input  logic                   clk,
    input  logic                   rst_n,
    i2s_bus_if.snk                 bus,
    input  logic                   take_bit,
    input  logic                   word_done,
    input  logic                   word_right,
    output i2s_types_pkg::sample_t left_sample,
    output i2s_types_pkg::sample_t right_sample
);
    import i2s_cfg_pkg::*;
    import i2s_types_pkg::*;

    sample_t cur_word;    // Word being assembled
    sample_t bit_ptr;     // One-hot slot for the next bit, MSB first
    sample_t word_nxt;    // cur_word including this rise's bit

    // Bit of the current rise, so the last LSB makes it into the latch
    always_comb
    begin
        word_nxt = cur_word;
        if (bus.sck_rise && take_bit && bus.sd_bit)
            word_nxt = cur_word | bit_ptr;
    end

    ////////////////////////////////////////////////
    // Current word
    ////////////////////////////////////////////////

    // Pointer walks down from the MSB, a short slot leaves the
    // low bits at zero so the word ends up left-aligned
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cur_word <= '0;
            bit_ptr  <= {1'b1, {(SAMPLE_W-1){1'b0}}};
        end
        else if (bus.sck_rise)
        begin
            if (bus.ws_flip)
            begin
                cur_word <= '0;                              // Also drops align junk
                bit_ptr  <= {1'b1, {(SAMPLE_W-1){1'b0}}};
            end
            else if (take_bit)
            begin
                cur_word <= word_nxt;
                bit_ptr  <= bit_ptr >> 1;
            end
        end
    end

    // Holding registers, overwritten by each new word
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            left_sample  <= '0;
            right_sample <= '0;
        end
        else if (word_done)
        begin
            if (word_right)
                right_sample <= word_nxt;
            else
                left_sample  <= word_nxt;
        end
    end

endmodule

// File: hdl/i2s_rx_top.sv
module i2s_rx_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sck,
    input  logic                   sd,
    input  logic                   ws,
    output i2s_types_pkg::sample_t left_sample,
    output i2s_types_pkg::sample_t right_sample,
    output logic                   sample_valid
);

    logic take_bit;      // Counter lets the shifter take a bit
    logic word_done;     // Slot ended, latch the word
    logic word_right;    // Ending slot is the right channel

    ////////////////////////////////////////////////
    // Synchronized serial bus
    ////////////////////////////////////////////////

    i2s_bus_if bus ();

    i2s_sync u_sync (
        .clk     (clk),
        .rst_n   (rst_n),
        .sck_pin (sck),
        .sd_pin  (sd),
        .ws_pin  (ws),
        .bus     (bus.src)
    );

    ////////////////////////////////////////////////
    // Slot tracking and word assembly
    ////////////////////////////////////////////////

    i2s_bit_counter u_bit_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (bus.snk),
        .take_bit (take_bit)
    );

    i2s_frame_ctrl u_frame_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (bus.snk),
        .word_done    (word_done),
        .word_right   (word_right),
        .sample_valid (sample_valid)    // Straight to the pin
    );

    i2s_word_shifter u_word_shifter (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (bus.snk),
        .take_bit     (take_bit),
        .word_done    (word_done),
        .word_right   (word_right),
        .left_sample  (left_sample),
        .right_sample (right_sample)
    );

endmodule

// File: dv/i2s_rx_asserts.sv
module i2s_rx_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input i2s_types_pkg::sample_t left_sample,
    input i2s_types_pkg::sample_t right_sample,
    input logic                   sample_valid
);

    int unsigned fail_cnt = 0;    // Failed assertions so far

    // Pair strobe lasts one cycle
    a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
    else
    begin
        fail_cnt++;
        $error("sample_valid high for two cycles in a row");
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !sample_valid)
    else
    begin
        fail_cnt++;
        $error("sample_valid high during reset");
    end

    // Right word is latched in the same edge that raises the strobe
    a_right_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(right_sample) |-> sample_valid)
    else
    begin
        fail_cnt++;
        $error("right_sample changed without a strobe");
    end

    // Left word settled a whole slot earlier
    a_left_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |-> $stable(left_sample))
    else
    begin
        fail_cnt++;
        $error("left_sample changed together with the strobe");
    end

endmodule

// File: dv/i2s_rx_tb.sv
module i2s_rx_tb;
    import i2s_cfg_pkg::*;
    import i2s_types_pkg::*;

    localparam int HALF_SCK = 4;       // clk cycles per sck half period
    localparam int WAIT_MAX = 2000;    // Strobe timeout in clk cycles

    logic    clk;
    logic    rst_n;
    logic    sck;
    logic    sd;
    logic    ws;
    sample_t left_sample;
    sample_t right_sample;
    logic    sample_valid;

    sample_t exp_left[$];     // Expected pairs, oldest first
    sample_t exp_right[$];
    sample_t got_left[$];     // Pairs seen with the strobe
    sample_t got_right[$];

    i2s_rx_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .sck          (sck),
        .sd           (sd),
        .ws           (ws),
        .left_sample  (left_sample),
        .right_sample (right_sample),
        .sample_valid (sample_valid)
    );

    bind i2s_rx_top i2s_rx_asserts u_asserts (
        .clk          (clk),
        .rst_n        (rst_n),
        .left_sample  (left_sample),
        .right_sample (right_sample),
        .sample_valid (sample_valid)
    );

    always #20 clk = ~clk;    // 40 unit period

    // Capture pairs mid-cycle, away from the driving edge
    always @(negedge clk)
    begin
        if (rst_n && sample_valid)
        begin
            got_left.push_back(left_sample);
            got_right.push_back(right_sample);
        end
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (exp !== act)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("tests failed");
            $fatal(1, "%s: sample mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("tests failed");
            $fatal(1, "%s: bit mismatch", name);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
        begin
            $display("ERR %s expected %0d actual %0d strobes", name, exp, act);
            $display("tests failed");
            $fatal(1, "%s: strobe count mismatch", name);
        end
    endtask

    task automatic wait_valid(input string name, input int n);
        int cycles;
        cycles = 0;
        while (got_left.size() < n)
        begin
            if (cycles == WAIT_MAX)
            begin
                $display("%s: no sample pair arrived within %0d cycles", name, WAIT_MAX);
                $display("tests failed");
                $fatal(1, "%s: timeout on sample_valid", name);
            end
            else
            begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // I2S transmitter model
    //////////////////////////////////////////////////

    // sd and ws change with the sck fall
    task automatic send_bit(input logic b, input logic w);
        @(posedge clk);
        sck <= 1'b0;
        sd  <= b;
        ws  <= w;
        repeat (HALF_SCK) @(posedge clk);
        sck <= 1'b1;
        repeat (HALF_SCK - 1) @(posedge clk);
    endtask

    // Last bit already carries the ws of the next slot
    task automatic send_slot(input logic ws_val, input logic [31:0] data, input int len,
                             input logic ws_next);
        for (int i = len - 1; i >= 0; i--)
            send_bit(data[i], (i == 0) ? ws_next : ws_val);
    endtask

    // MSB of the slot lands on the sample MSB, extra bits drop, missing ones read zero
    function automatic sample_t expect_word(input logic [31:0] data, input int len);
        logic [31:0] aligned;
        aligned = data << (32 - len);
        return aligned[31 -: SAMPLE_W];
    endfunction

    task automatic send_frame(input logic [31:0] l, input logic [31:0] r, input int len);
        exp_left.push_back(expect_word(l, len));
        exp_right.push_back(expect_word(r, len));
        send_slot(1'b0, l, len, 1'b1);
        send_slot(1'b1, r, len, 1'b0);    // Ends back on left
    endtask

    task automatic check_frames(input string name);
        int n;
        n = exp_left.size();
        wait_valid(name, n);
        repeat (4 * HALF_SCK) @(posedge clk);    // Room for a stray strobe
        check_count(name, n, got_left.size());
        for (int i = 0; i < n; i++)
        begin
            check_sample(name, exp_left[i], got_left[i]);
            check_sample(name, exp_right[i], got_right[i]);
        end
        exp_left.delete();
        exp_right.delete();
        got_left.delete();
        got_right.delete();
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        @(negedge clk);
        check_bit("reset", 1'b0, sample_valid);
        check_sample("reset", '0, left_sample);
        check_sample("reset", '0, right_sample);
        repeat (200) @(posedge clk);    // sck idle
        check_count("reset_idle", 0, got_left.size());
    endtask

    task automatic test_one_frame();
        send_slot(1'b1, 32'h0000_5a5a, 16, 1'b0);    // Partial frame, dropped
        send_frame(32'h0000_1234, 32'h0000_abcd, 16);
        check_frames("one_frame");
    endtask

    task automatic test_long_slots();
        send_frame(32'h00a1_b2c3, 32'h00d4_e5f6, 24);
        check_frames("long_slots");
    endtask

    task automatic test_short_slots();
        send_frame(32'h0000_0abc, 32'h0000_0123, 12);
        check_frames("short_slots");
    endtask

    task automatic test_stream();
        for (int f = 0; f < 20; f++)
            send_frame($urandom(), $urandom(), 16);
        check_frames("stream");
    endtask

    initial
    begin
        void'($urandom(32'hc281));
        clk   = 1'b0;
        rst_n = 1'b0;
        sck   = 1'b0;
        sd    = 1'b0;
        ws    = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_one_frame();
        test_long_slots();
        test_short_slots();
        test_stream();
        if (dut.u_asserts.fail_cnt == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            $display("tests failed");
            $fatal(1, "%0d assertion failures", dut.u_asserts.fail_cnt);
        end
    end

endmodule

// File: src.f
hdl/i2s_cfg_pkg.sv
hdl/i2s_types_pkg.sv
hdl/i2s_bus_if.sv
hdl/i2s_sync.sv
hdl/i2s_bit_counter.sv
hdl/i2s_frame_ctrl.sv
hdl/i2s_word_shifter.sv
hdl/i2s_rx_top.sv
dv/i2s_rx_asserts.sv
dv/i2s_rx_tb.sv

// File: Bender.yml
package:
  name: i2s_rx

sources:
  - hdl/i2s_cfg_pkg.sv
  - hdl/i2s_types_pkg.sv
  - hdl/i2s_bus_if.sv
  - hdl/i2s_sync.sv
  - hdl/i2s_bit_counter.sv
  - hdl/i2s_frame_ctrl.sv
  - hdl/i2s_word_shifter.sv
  - hdl/i2s_rx_top.sv
  - target: test
    files:
      - dv/i2s_rx_asserts.sv
      - dv/i2s_rx_tb.sv
